//--- common/colmix_cfg.svh
// Fixed widths and pixel constants of the colour mixer, included by its packages and RTL
`ifndef COLMIX_CFG_SVH
`define COLMIX_CFG_SVH

// Output palette index and its parts
`define COLMIX_PXL_W     12
`define COLMIX_CODE_W    3
`define COLMIX_COLOUR_W  9
`define COLMIX_PEN_W     4
`define COLMIX_GROUP_W   2

// Raw layer pixel widths
`define COLMIX_OBJ_W     9
`define COLMIX_SCR_W     11
`define COLMIX_STAR_W    7

// Register widths
`define COLMIX_CTRL_W    16
`define COLMIX_MASK_W    8
`define COLMIX_PRIO_W    16

// Layer and depth slot counts
`define COLMIX_LAYERS    6
`define COLMIX_MAIN      4

// Pen 15 is see-through on every layer
`define COLMIX_PEN_TRANSP 4'hF
`define COLMIX_BLANK_PXL  12'hFFF

`endif

//--- common/colmix_pxl_pkg.sv
// Pixel-side types of the colour mixer: layer codes, raw layer pixels and depth slots
`default_nettype none

`include "colmix_cfg.svh"

package colmix_pxl_pkg;

    // Source layer code, top three bits of the palette index
    typedef enum logic [`COLMIX_CODE_W-1:0] {
        OBJ   = 3'd0,
        SCR1  = 3'd1,
        SCR2  = 3'd2,
        SCR3  = 3'd3,
        STAR0 = 3'd4,
        STAR1 = 3'd5
    } layer_code_e;

    // One candidate pixel per layer, as delivered by the generators
    typedef struct packed {
        // Object colour, pen in bits 3:0
        logic [`COLMIX_OBJ_W-1:0]  obj;
        // Scroll pixels carry the priority group in bits 10:9
        logic [`COLMIX_SCR_W-1:0]  scr1;
        logic [`COLMIX_SCR_W-1:0]  scr2;
        logic [`COLMIX_SCR_W-1:0]  scr3;
        // Star field pixels
        logic [`COLMIX_STAR_W-1:0] star0;
        logic [`COLMIX_STAR_W-1:0] star1;
    } layer_pixels_t;

    // One depth slot
    // code and colour together form the 12-bit output pixel
    typedef struct packed {
        // Priority group, only meaningful for scroll layers
        logic [`COLMIX_GROUP_W-1:0]  group;
        layer_code_e                 code;
        // Pen sits in the low bits
        logic [`COLMIX_COLOUR_W-1:0] colour;
    } slot_t;

endpackage

`default_nettype wire

//--- common/colmix_regs_pkg.sv
// Register-side types of the colour mixer: decoded register levels and layer enables
`default_nettype none

`include "colmix_cfg.svh"

package colmix_regs_pkg;

    // Video control register, depth order in 13:6, layer bits in 5:0
    typedef logic [`COLMIX_CTRL_W-1:0] layer_ctrl_t;

    // Per-group pen masks, a set bit puts the scroll pen in front of objects
    typedef logic [3:0][`COLMIX_PRIO_W-1:0] prio_masks_t;

    // Register levels seen by the mixer
    typedef struct packed {
        layer_ctrl_t                   layer_ctrl;
        // Scroll DMA enables, scroll n on bit n
        logic [3:1]                    scrdma_en;
        // Graphics enables, bit 3 is objects
        logic [3:0]                    gfx_en;
        // Masks 0-2 for scrolls, 3-4 for the star fields
        logic [4:0][`COLMIX_MASK_W-1:0] layer_mask;
        prio_masks_t                   prio;
    } mixer_regs_t;

    // One enable per layer, indexed by layer code
    typedef logic [`COLMIX_LAYERS-1:0] layer_en_t;

endpackage

`default_nettype wire

//--- colmix/layer_enable.sv
// Layer enable decode of the colour mixer, instantiated once in the mixer top level
`default_nettype none
`timescale 1ns/1ps

`include "colmix_cfg.svh"

module layer_enable (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        pxl_cen,
    input  colmix_regs_pkg::mixer_regs_t regs,
    output colmix_regs_pkg::layer_en_t   en,
    output logic [1:0]                  star_en
);

    // Mask against control layer bits, one per mask register
    logic [4:0]                 mask_hit;
    colmix_regs_pkg::layer_en_t en_nxt;

    always_comb begin
        for (int i = 0; i < 5; i++) begin
            mask_hit[i] = |(regs.layer_mask[i][5:0] & regs.layer_ctrl[5:0]);
        end
    end

    always_comb begin
        en_nxt = '0;
        // Objects only switch off through the graphics enable
        en_nxt[colmix_pxl_pkg::OBJ] = regs.gfx_en[3];
        // Scrolls also need their DMA running
        en_nxt[colmix_pxl_pkg::SCR1] = mask_hit[0] & regs.scrdma_en[1] & regs.gfx_en[0];
        en_nxt[colmix_pxl_pkg::SCR2] = mask_hit[1] & regs.scrdma_en[2] & regs.gfx_en[1];
        en_nxt[colmix_pxl_pkg::SCR3] = mask_hit[2] & regs.scrdma_en[3] & regs.gfx_en[2];
        // Stars follow the mask decode alone
        en_nxt[colmix_pxl_pkg::STAR0] = mask_hit[3];
        en_nxt[colmix_pxl_pkg::STAR1] = mask_hit[4];
    end

    // Sampled with the pixels so enables match the slot contents
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en <= '0;
        end else if (pxl_cen) begin
            en <= en_nxt;
        end
    end

    // Star generator enables, free running
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            star_en <= 2'b00;
        end else begin
            star_en <= mask_hit[4:3];
        end
    end

    // Undriven register bits must not leak into the arbiter
    a_en_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        pxl_cen |=> !$isunknown(en)
    );

endmodule

`default_nettype wire

//--- colmix/slot_order.sv
// Depth ordering of the colour mixer, loads six slots per pixel strobe for the arbiter
`default_nettype none
`timescale 1ns/1ps

`include "colmix_cfg.svh"

module slot_order (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         pxl_cen,
    input  colmix_pxl_pkg::layer_pixels_t                pixels,
    input  colmix_regs_pkg::layer_ctrl_t                 layer_ctrl,
    output colmix_pxl_pkg::slot_t [`COLMIX_LAYERS-1:0]   slots
);

    // Transparent slot used at reset
    localparam colmix_pxl_pkg::slot_t SLOT_EMPTY = '{
        group:  '0,
        code:   colmix_pxl_pkg::OBJ,
        colour: '1
    };

    // Main layers in control field encoding order
    colmix_pxl_pkg::slot_t [`COLMIX_MAIN-1:0]   main_slot;
    colmix_pxl_pkg::slot_t [`COLMIX_LAYERS-1:0] slot_nxt;

    always_comb begin
        // Objects have no group of their own
        main_slot[0] = '{
            group:  '0,
            code:   colmix_pxl_pkg::OBJ,
            colour: pixels.obj
        };
        main_slot[1] = '{
            group:  pixels.scr1[`COLMIX_SCR_W-1 -: `COLMIX_GROUP_W],
            code:   colmix_pxl_pkg::SCR1,
            colour: pixels.scr1[`COLMIX_COLOUR_W-1:0]
        };
        main_slot[2] = '{
            group:  pixels.scr2[`COLMIX_SCR_W-1 -: `COLMIX_GROUP_W],
            code:   colmix_pxl_pkg::SCR2,
            colour: pixels.scr2[`COLMIX_COLOUR_W-1:0]
        };
        main_slot[3] = '{
            group:  pixels.scr3[`COLMIX_SCR_W-1 -: `COLMIX_GROUP_W],
            code:   colmix_pxl_pkg::SCR3,
            colour: pixels.scr3[`COLMIX_COLOUR_W-1:0]
        };
    end

    // Slot 0 is the front, its field is 13:12
    for (genvar i = 0; i < `COLMIX_MAIN; i++) begin : g_sel
        assign slot_nxt[i] = main_slot[layer_ctrl[13 - 2*i -: 2]];
    end

    // Stars always behind, colour zero padded
    assign slot_nxt[4] = '{
        group:  '0,
        code:   colmix_pxl_pkg::STAR0,
        colour: {2'b00, pixels.star0}
    };
    assign slot_nxt[5] = '{
        group:  '0,
        code:   colmix_pxl_pkg::STAR1,
        colour: {2'b00, pixels.star1}
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slots <= {`COLMIX_LAYERS{SLOT_EMPTY}};
        end else if (pxl_cen) begin
            slots <= slot_nxt;
        end
    end

endmodule

`default_nettype wire

//--- colmix/pixel_arbiter.sv
// Final pixel choice of the colour mixer, front-most visible slot with object priority
`default_nettype none
`timescale 1ns/1ps

`include "colmix_cfg.svh"

module pixel_arbiter (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       pxl_cen,
    input  colmix_pxl_pkg::slot_t [`COLMIX_LAYERS-1:0] slots,
    input  colmix_regs_pkg::layer_en_t                 en,
    input  colmix_regs_pkg::prio_masks_t               prio,
    output logic [`COLMIX_PXL_W-1:0]                   pxl
);

    logic [`COLMIX_LAYERS-1:0] visible;
    logic [`COLMIX_LAYERS-1:0] skip;
    logic [`COLMIX_LAYERS-1:0] show;
    logic [`COLMIX_PXL_W-1:0]  pick;
    // Result computed between strobes
    logic [`COLMIX_PXL_W-1:0]  nx_pxl;
    logic                      cen_seen;

    // Enabled and not see-through
    always_comb begin
        for (int i = 0; i < `COLMIX_LAYERS; i++) begin
            visible[i] = en[slots[i].code] &&
                (slots[i].colour[`COLMIX_PEN_W-1:0] != `COLMIX_PEN_TRANSP);
        end
    end

    // Object hidden by the scroll slot right behind it
    // Scroll enable and transparency are not checked here
    for (genvar i = 0; i < `COLMIX_MAIN - 1; i++) begin : g_prio
        logic behind_scr;
        logic prio_bit;

        assign behind_scr = slots[i+1].code inside
            {colmix_pxl_pkg::SCR1, colmix_pxl_pkg::SCR2, colmix_pxl_pkg::SCR3};
        // Group picks the mask, pen picks the bit
        assign prio_bit = prio[slots[i+1].group][slots[i+1].colour[`COLMIX_PEN_W-1:0]];
        assign skip[i] = (slots[i].code == colmix_pxl_pkg::OBJ) && behind_scr && prio_bit;
    end

    // Back slot and stars are never overridden
    assign skip[`COLMIX_LAYERS-1:`COLMIX_MAIN-1] = '0;
    assign show = visible & ~skip;

    // Scan back to front so the front-most hit wins
    always_comb begin
        pick = `COLMIX_BLANK_PXL;
        for (int i = `COLMIX_LAYERS - 1; i >= 0; i--) begin
            if (show[i]) begin
                pick = {slots[i].code, slots[i].colour};
            end
        end
    end

    // Compute on quiet cycles, present on the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            nx_pxl <= `COLMIX_BLANK_PXL;
            pxl    <= `COLMIX_BLANK_PXL;
        end else if (pxl_cen) begin
            pxl <= nx_pxl;
        end else begin
            nx_pxl <= pick;
        end
    end

    // Marks the first strobe after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_seen <= 1'b0;
        end else if (pxl_cen) begin
            cen_seen <= 1'b1;
        end
    end

    // Strobe must leave a quiet cycle for the result register
    a_cen_spaced: assert property (
        @(posedge clk) disable iff (!arst_n)
        pxl_cen |=> !pxl_cen
    );

    // Reset slots and enables give a blank first pixel
    a_first_blank: assert property (
        @(posedge clk) disable iff (!arst_n)
        (pxl_cen && !cen_seen) |=> (pxl == `COLMIX_BLANK_PXL)
    );

endmodule

`default_nettype wire

//--- verilog/colmix_top.sv
// Colour mixer top level, one palette index per pixel strobe from six graphics layers
`default_nettype none
`timescale 1ns/1ps

`include "colmix_cfg.svh"

module colmix_top (
    input  logic                          clk,
    input  logic                          arst_n,
    // One-cycle strobe, never on back-to-back clocks
    input  logic                          pxl_cen,
    input  colmix_pxl_pkg::layer_pixels_t pixels,
    input  colmix_regs_pkg::mixer_regs_t  regs,
    // To the star field generators
    output logic [1:0]                    star_en,
    // Palette RAM address
    output logic [`COLMIX_PXL_W-1:0]      pxl
);

    // Layer enables aligned with the slots
    colmix_regs_pkg::layer_en_t                 en;
    // Ordered slots, front first
    colmix_pxl_pkg::slot_t [`COLMIX_LAYERS-1:0] slots;

    layer_enable u_layer_enable (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .regs    (regs),
        .en      (en),
        .star_en (star_en)
    );

    slot_order u_slot_order (
        .clk        (clk),
        .arst_n     (arst_n),
        .pxl_cen    (pxl_cen),
        .pixels     (pixels),
        .layer_ctrl (regs.layer_ctrl),
        .slots      (slots)
    );

    // One strobe behind the slot load
    pixel_arbiter u_pixel_arbiter (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .slots   (slots),
        .en      (en),
        .prio    (regs.prio),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

//--- dv/colmix_tb_table.svh
// Directed rows and reference model that the colour mixer testbench includes
`ifndef COLMIX_TB_TABLE_SVH
`define COLMIX_TB_TABLE_SVH

// Each row holds name, layer_ctrl, scrdma_en, gfx_en, masks 4..0 and prio 3..0
// then pixels {obj, scr1, scr2, scr3, star0, star1}, expected pxl and expected star_en
typedef struct {
    string                         name;
    logic [15:0]                   ctrl;
    logic [2:0]                    dma;
    logic [3:0]                    gfx;
    logic [39:0]                   mask;
    logic [63:0]                   prio;
    colmix_pxl_pkg::layer_pixels_t pix;
    logic [`COLMIX_PXL_W-1:0]      exp_pxl;
    logic [1:0]                    exp_star;
} row_t;

// Control 06FF orders obj, scr1, scr2, scr3 and 12FF, 21FF, 31FF bring scr1, scr2, scr3 forward
row_t rows [18] = '{
    '{"order_obj", 16'h06FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h012, 2'h3},
    '{"order_scr1", 16'h12FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h223, 2'h3},
    '{"order_scr2", 16'h21FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h434, 2'h3},
    '{"order_scr3", 16'h31FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h645, 2'h3},
    '{"transp_obj", 16'h06FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h01F, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h223, 2'h3},
    '{"transp_main", 16'h06FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h01F, 11'h02F, 11'h03F, 11'h04F, 7'h56, 7'h67}, 12'h856, 2'h3},
    '{"transp_star0", 16'h06FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h01F, 11'h02F, 11'h03F, 11'h04F, 7'h5F, 7'h67}, 12'hA67, 2'h3},
    '{"transp_all", 16'h06FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h01F, 11'h02F, 11'h03F, 11'h04F, 7'h5F, 7'h6F}, 12'hFFF, 2'h3},
    '{"en_mask", 16'h06FF, 3'h7, 4'hF, 40'h3F3F3F3F00, 64'h0,
        {9'h01F, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h434, 2'h3},
    '{"en_ctrl_bit", 16'h06FE, 3'h7, 4'hF, 40'h3F3F3F3F01, 64'h0,
        {9'h01F, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h434, 2'h3},
    '{"en_scrdma", 16'h06FF, 3'h6, 4'hF, 40'h3F3F3F3F3F, 64'h0,
        {9'h01F, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h434, 2'h3},
    '{"en_gfx", 16'h06FF, 3'h7, 4'hE, 40'h3F3F3F3F3F, 64'h0,
        {9'h01F, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h434, 2'h3},
    '{"en_obj_off", 16'h06FF, 3'h7, 4'h7, 40'h3F3F3F3F3F, 64'h0,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h223, 2'h3},
    '{"en_obj_kept", 16'h06FF, 3'h7, 4'h8, 40'h3F3F3F3F3F, 64'h0,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h012, 2'h3},
    '{"star_en_decode", 16'h06FF, 3'h7, 4'hF, 40'h3F003F3F3F, 64'h0,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h012, 2'h2},
    '{"prio_scr_front", 16'h06FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h8,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h223, 2'h3},
    '{"prio_group_clear", 16'h06FF, 3'h7, 4'hF, 40'h3F3F3F3F3F, 64'h8,
        {9'h012, 11'h223, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h012, 2'h3},
    '{"prio_scr_disabled", 16'h06FF, 3'h6, 4'hF, 40'h3F3F3F3F3F, 64'h8,
        {9'h012, 11'h023, 11'h034, 11'h045, 7'h56, 7'h67}, 12'h434, 2'h3}
};

// Reference pixel from the enable, slot and priority rules
function automatic logic [`COLMIX_PXL_W-1:0] reference_pixel(
    colmix_pxl_pkg::layer_pixels_t p,
    colmix_regs_pkg::mixer_regs_t  r
);
    logic [7:0]               on;
    logic [8:0]               colour [8];
    logic [1:0]               group [8];
    logic [2:0]               code [6];
    logic [2:0]               back;
    logic                     skip;
    logic                     found;
    logic [`COLMIX_PXL_W-1:0] res;
    // Indexed by layer code
    colour = '{p.obj, p.scr1[8:0], p.scr2[8:0], p.scr3[8:0],
        {2'b00, p.star0}, {2'b00, p.star1}, 9'h0, 9'h0};
    group = '{2'b00, p.scr1[10:9], p.scr2[10:9], p.scr3[10:9], 2'b00, 2'b00, 2'b00, 2'b00};
    on = '0;
    on[0] = r.gfx_en[3];
    for (int n = 1; n <= 3; n++) begin
        on[n] = |(r.layer_mask[n-1][5:0] & r.layer_ctrl[5:0]) & r.scrdma_en[n] & r.gfx_en[n-1];
    end
    on[4] = |(r.layer_mask[3][5:0] & r.layer_ctrl[5:0]);
    on[5] = |(r.layer_mask[4][5:0] & r.layer_ctrl[5:0]);
    // Front slot first
    for (int s = 0; s < 4; s++) begin
        code[s] = {1'b0, r.layer_ctrl[13-2*s -: 2]};
    end
    code[4] = 3'd4;
    code[5] = 3'd5;
    res = `COLMIX_BLANK_PXL;
    found = 1'b0;
    for (int s = 0; s < 6; s++) begin
        skip = 1'b0;
        // Object loses to a prioritised scroll pen right behind it
        if (s < 3 && code[s] == 3'd0) begin
            back = code[s+1];
            skip = (back != 3'd0) && r.prio[group[back]][colour[back][3:0]];
        end
        if (!found && !skip && on[code[s]] &&
            colour[code[s]][3:0] != `COLMIX_PEN_TRANSP) begin
            res = {code[s], colour[code[s]]};
            found = 1'b1;
        end
    end
    return res;
endfunction

// Star enables from the two star masks
function automatic logic [1:0] star_enables(colmix_regs_pkg::mixer_regs_t r);
    return {|(r.layer_mask[4][5:0] & r.layer_ctrl[5:0]),
        |(r.layer_mask[3][5:0] & r.layer_ctrl[5:0])};
endfunction

`endif

//--- dv/colmix_tb.sv
// Self-checking testbench of the colour mixer that runs directed table rows and then seeded random rows
`default_nettype none
`timescale 1ns/1ps

`include "colmix_cfg.svh"

module colmix_tb;

    localparam int STROBE_TIMEOUT = 20;
    localparam int RANDOM_ROWS    = 20;
    localparam int PIXELS_W       = $bits(colmix_pxl_pkg::layer_pixels_t);

    logic                          clk;
    logic                          arst_n;
    logic                          pxl_cen;
    colmix_pxl_pkg::layer_pixels_t pixels;
    colmix_regs_pkg::mixer_regs_t  regs;
    logic [1:0]                    star_en;
    logic [`COLMIX_PXL_W-1:0]      pxl;

    int          pass_cnt;
    int          fail_cnt;
    logic [31:0] rng;
    logic [63:0] bits;

`include "colmix_tb_table.svh"

    colmix_top u_colmix_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .pixels  (pixels),
        .regs    (regs),
        .star_en (star_en),
        .pxl     (pxl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Strobe toggles on every falling edge after reset
    initial begin
        pxl_cen = 1'b0;
        @(posedge arst_n);
        forever begin
            @(negedge clk);
            pxl_cen = ~pxl_cen;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Two steps of the generator
    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        rng = xorshift(rng);
        hi = rng;
        rng = xorshift(rng);
        return {hi, rng};
    endfunction

    // Returns at the rising edge that samples a strobe
    task automatic wait_strobe();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!pxl_cen && cycles < STROBE_TIMEOUT);
        if (!pxl_cen) begin
            $display("Timed out waiting for the pixel strobe");
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic compare_outputs(string name, logic [11:0] exp_pxl, logic [1:0] exp_star);
        a_outputs: assert (pxl == exp_pxl && star_en == exp_star) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("** Error %s: expected pxl %h star_en %b, actual pxl %h star_en %b",
                name, exp_pxl, exp_star, pxl, star_en);
        end
    endtask

    // Row sampled at strobe k appears at strobe k+1 and is checked on the next falling edge
    task automatic check_row(string name, logic [11:0] exp_pxl, logic [1:0] exp_star);
        wait_strobe();
        wait_strobe();
        @(negedge clk);
        compare_outputs(name, exp_pxl, exp_star);
    endtask

    initial begin
        arst_n   = 1'b0;
        pixels   = '0;
        regs     = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        rng      = 32'd92565;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        compare_outputs("reset_state", `COLMIX_BLANK_PXL, 2'b00);

        foreach (rows[i]) begin
            pixels          = rows[i].pix;
            regs.layer_ctrl = rows[i].ctrl;
            regs.scrdma_en  = rows[i].dma;
            regs.gfx_en     = rows[i].gfx;
            regs.layer_mask = rows[i].mask;
            regs.prio       = rows[i].prio;
            check_row(rows[i].name, rows[i].exp_pxl, rows[i].exp_star);
        end

        for (int n = 0; n < RANDOM_ROWS; n++) begin
            bits = rand64();
            pixels = bits[PIXELS_W-1:0];
            bits = rand64();
            regs.layer_ctrl = bits[15:0];
            regs.scrdma_en  = bits[18:16];
            regs.gfx_en     = bits[22:19];
            bits = rand64();
            regs.layer_mask = bits[39:0];
            regs.prio       = rand64();
            check_row($sformatf("random_%0d", n), reference_pixel(pixels, regs),
                star_enables(regs));
        end

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
+incdir+dv
common/colmix_pxl_pkg.sv
common/colmix_regs_pkg.sv
colmix/layer_enable.sv
colmix/slot_order.sv
colmix/pixel_arbiter.sv
verilog/colmix_top.sv
dv/colmix_tb.sv

//--- Makefile
# Verilator build and run of the colour mixer testbench

VERILATOR ?= verilator
TOP       ?= colmix_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/colmix_cfg.svh dv/colmix_tb_table.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
